/* axiLiteSlave.sv */
`timescale 1ns/10ps
`default_nettype none

module axiLiteSlave (
	input  logic clock,
	input  logic rstN,
	// write address and data
	input  logic awvalid,
	output logic awready,
	input  routingPkg::axiAddrT awaddr,
	input  logic wvalid,
	output logic wready,
	input  routingPkg::axiDataT wdata,
	// write response
	output logic bvalid,
	input  logic bready,
	output logic [1:0] bresp,
	// read address and data
	input  logic arvalid,
	output logic arready,
	input  routingPkg::axiAddrT araddr,
	output logic rvalid,
	input  logic rready,
	output routingPkg::axiDataT rdata,
	output logic [1:0] rresp,
	// memory port
	input  logic hostGrant,
	input  routingPkg::wordT rdData,
	output logic hostReq,
	output routingPkg::memAddrT hostAddr,
	output logic hostWrEn,
	output routingPkg::wordT hostWrData,
	// engine control
	input  logic busy,
	input  logic done,
	output logic startPulse,
	output routingPkg::wordT myCluster
);

	localparam logic [1:0] respOkay = 2'd0;
	localparam logic [1:0] respSlvErr = 2'd2;

	logic slaveIdle;
	logic wrPending, rdPending;
	logic wrAccept, rdAccept;
	logic wrIsMem, wrIsCtrl, wrIsCluster, wrIsStatus, wrMapped;
	logic rdIsMem, rdIsCtrl, rdIsCluster, rdIsStatus, rdMapped;
	routingPkg::axiDataT rdMux;

	// write side decode
	assign wrIsMem = awaddr < routingPkg::memWindowEnd;
	assign wrIsCtrl = awaddr == routingPkg::ctrlAddr;
	assign wrIsCluster = awaddr == routingPkg::clusterAddr;
	assign wrIsStatus = awaddr == routingPkg::statusAddr;
	assign wrMapped = wrIsMem || wrIsCtrl || wrIsCluster || wrIsStatus;

	// read side decode
	assign rdIsMem = araddr < routingPkg::memWindowEnd;
	assign rdIsCtrl = araddr == routingPkg::ctrlAddr;
	assign rdIsCluster = araddr == routingPkg::clusterAddr;
	assign rdIsStatus = araddr == routingPkg::statusAddr;
	assign rdMapped = rdIsMem || rdIsCtrl || rdIsCluster || rdIsStatus;

	// one transaction at a time, nothing new while a response waits
	assign slaveIdle = !bvalid && !rvalid;
	assign wrPending = slaveIdle && awvalid && wvalid;
	// writes go first when both arrive
	assign rdPending = slaveIdle && arvalid && !wrPending;

	// memory accesses wait for grant, registers never do
	assign wrAccept = wrPending && (!wrIsMem || hostGrant);
	assign rdAccept = rdPending && (!rdIsMem || hostGrant);
	assign awready = wrAccept;
	assign wready = wrAccept;
	assign arready = rdAccept;

	// request straight from the channel, odd address aligned down
	assign hostReq = (wrPending && wrIsMem) || (rdPending && rdIsMem);
	assign hostWrEn = wrPending;
	assign hostAddr = wrPending ? {awaddr[10:1], 1'b0} : {araddr[10:1], 1'b0};
	assign hostWrData = wdata[15:0];

	// read data select
	always_comb begin
		rdMux = '0;
		if (rdIsMem) begin
			rdMux = {16'h0000, rdData};
		end else if (rdIsCluster) begin
			rdMux = {16'h0000, myCluster};
		end else if (rdIsStatus) begin
			rdMux = {30'd0, done, busy};
		end
	end

	// handshake state and registers
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			startPulse <= 1'b0;
			myCluster <= '0;
		end else begin
			// single-cycle start strobe
			startPulse <= wrAccept && wrIsCtrl && wdata[0];
			if (wrAccept) begin
				bvalid <= 1'b1;
				if (wrIsCluster) begin
					myCluster <= wdata[15:0];
				end
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			if (rdAccept) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// response payload, held while valid
	always_ff @(posedge clock) begin
		if (wrAccept) begin
			bresp <= wrMapped ? respOkay : respSlvErr;
		end
		if (rdAccept) begin
			rresp <= rdMapped ? respOkay : respSlvErr;
			rdata <= rdMux;
		end
	end

endmodule

`default_nettype wire

/* clusterNeighborSearch.sv */
`timescale 1ns/10ps
`default_nettype none

module clusterNeighborSearch (
	input  logic clock,
	input  logic rstN,
	input  logic startPulse,
	input  routingPkg::wordT myCluster,
	input  routingPkg::wordT rdData,
	output logic engineReq,
	output routingPkg::memAddrT engineAddr,
	output logic engineWrEn,
	output routingPkg::wordT engineWrData,
	output logic busy,
	output logic done
);

	routingPkg::searchStateT state;
	// clamped neighbor count, up to 64
	logic [6:0] neighborCnt;
	logic [5:0] idx;
	routingPkg::memAddrT idxOffset;
	logic lastIdx;
	logic clusterMatch;
	logic newBest;
	logic takeId;
	logic found;
	routingPkg::wordT bestQ;
	routingPkg::wordT bestId;

	// word offset of current entry
	assign idxOffset = {4'b0000, idx, 1'b0};
	assign lastIdx = ({1'b0, idx} + 7'd1) == neighborCnt;

	// strictly greater keeps the lowest index on a tie
	assign newBest = clusterMatch && (!found || rdData > bestQ);

	// engine owns the memory whenever it runs
	assign busy = state != routingPkg::idle;
	assign engineReq = busy;
	assign engineWrEn = (state == routingPkg::writeBest) || (state == routingPkg::writeCount);

	// one word per state
	always_comb begin
		engineAddr = routingPkg::neighborCountAddr;
		engineWrData = '0;
		case (state)
			routingPkg::readCluster: engineAddr = routingPkg::clusterIdBase + idxOffset;
			routingPkg::readQ: engineAddr = routingPkg::qValueBase + idxOffset;
			routingPkg::readId: engineAddr = routingPkg::neighborIdBase + idxOffset;
			routingPkg::writeBest: begin
				engineAddr = routingPkg::betterNeighborBase;
				engineWrData = found ? bestId : '0;
			end
			routingPkg::writeCount: begin
				engineAddr = routingPkg::betterNeighborCountAddr;
				engineWrData = {15'd0, found};
			end
			default: engineAddr = routingPkg::neighborCountAddr;
		endcase
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= routingPkg::idle;
			done <= 1'b0;
			neighborCnt <= '0;
			idx <= '0;
			clusterMatch <= 1'b0;
			takeId <= 1'b0;
			found <= 1'b0;
		end else begin
			case (state)
				routingPkg::idle: begin
					// start while busy never reaches here
					if (startPulse) begin
						state <= routingPkg::readCount;
						done <= 1'b0;
						found <= 1'b0;
						idx <= '0;
					end
				end
				routingPkg::readCount: begin
					if (rdData > 16'(routingPkg::maxNeighbors)) begin
						neighborCnt <= 7'(routingPkg::maxNeighbors);
					end else begin
						neighborCnt <= rdData[6:0];
					end
					// empty table skips the scan
					state <= (rdData == '0) ? routingPkg::writeBest : routingPkg::readCluster;
				end
				routingPkg::readCluster: begin
					clusterMatch <= rdData == myCluster;
					state <= routingPkg::readQ;
				end
				routingPkg::readQ: begin
					takeId <= newBest;
					if (newBest) begin
						found <= 1'b1;
					end
					state <= routingPkg::readId;
				end
				routingPkg::readId: begin
					idx <= idx + 6'd1;
					state <= lastIdx ? routingPkg::writeBest : routingPkg::readCluster;
				end
				routingPkg::writeBest: state <= routingPkg::writeCount;
				routingPkg::writeCount: begin
					state <= routingPkg::idle;
					done <= 1'b1;
				end
				default: state <= routingPkg::idle;
			endcase
		end
	end

	// best candidate payload
	always_ff @(posedge clock) begin
		if (state == routingPkg::readQ && newBest) begin
			bestQ <= rdData;
		end
		if (state == routingPkg::readId && takeId) begin
			bestId <= rdData;
		end
	end

endmodule

`default_nettype wire

/* nodeMemory.sv */
`timescale 1ns/10ps
`default_nettype none

module nodeMemory #(
	parameter int memDepth = 2048
) (
	input  logic clock,
	input  logic engineReq,
	input  routingPkg::memAddrT engineAddr,
	input  logic engineWrEn,
	input  routingPkg::wordT engineWrData,
	input  logic hostReq,
	input  routingPkg::memAddrT hostAddr,
	input  logic hostWrEn,
	input  routingPkg::wordT hostWrData,
	output routingPkg::wordT rdData,
	output logic hostGrant
);

	// byte storage, tables loaded by host
	logic [7:0] mem [memDepth];

	routingPkg::memAddrT selAddr;
	routingPkg::memAddrT hiAddr;
	routingPkg::memAddrT loAddr;
	routingPkg::wordT wrData;
	logic wrEn;

	// engine always wins the port
	assign hostGrant = hostReq && !engineReq;
	assign selAddr = engineReq ? engineAddr : hostAddr;

	// high byte at even address
	assign hiAddr = {selAddr[10:1], 1'b0};
	assign loAddr = {selAddr[10:1], 1'b1};

	assign wrEn = engineReq ? engineWrEn : (hostGrant && hostWrEn);
	assign wrData = engineReq ? engineWrData : hostWrData;

	// read is combinational, valid in grant cycle
	assign rdData = {mem[hiAddr], mem[loAddr]};

	// whole word stored on the edge
	always_ff @(posedge clock) begin
		if (wrEn) begin
			mem[hiAddr] <= wrData[15:8];
			mem[loAddr] <= wrData[7:0];
		end
	end

endmodule

`default_nettype wire

/* routingNode.f */
routingPkg.sv
nodeMemory.sv
axiLiteSlave.sv
clusterNeighborSearch.sv
routingNode.sv
routingNode_chk.sv
tbRoutingNode.sv

/* routingNode.sv */
`timescale 1ns/10ps
`default_nettype none

module routingNode #(
	parameter int memDepth = 2048
) (
	input  logic clock,
	input  logic rstN,
	input  logic awvalid,
	output logic awready,
	input  routingPkg::axiAddrT awaddr,
	input  logic wvalid,
	output logic wready,
	input  routingPkg::axiDataT wdata,
	output logic bvalid,
	input  logic bready,
	output logic [1:0] bresp,
	input  logic arvalid,
	output logic arready,
	input  routingPkg::axiAddrT araddr,
	output logic rvalid,
	input  logic rready,
	output routingPkg::axiDataT rdata,
	output logic [1:0] rresp
);

	// host port
	logic hostReq, hostWrEn, hostGrant;
	routingPkg::memAddrT hostAddr;
	routingPkg::wordT hostWrData;
	// engine port
	logic engineReq, engineWrEn;
	routingPkg::memAddrT engineAddr;
	routingPkg::wordT engineWrData;
	// shared read bus
	routingPkg::wordT rdData;
	// control
	logic startPulse, busy, done;
	routingPkg::wordT myCluster;

	axiLiteSlave bridge (
		.clock, .rstN,
		.awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
		.bvalid, .bready, .bresp,
		.arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
		.hostGrant, .rdData, .hostReq, .hostAddr, .hostWrEn, .hostWrData,
		.busy, .done, .startPulse, .myCluster
	);

	clusterNeighborSearch search (
		.clock, .rstN, .startPulse, .myCluster, .rdData,
		.engineReq, .engineAddr, .engineWrEn, .engineWrData, .busy, .done
	);

	nodeMemory #(.memDepth(memDepth)) memory (
		.clock,
		.engineReq, .engineAddr, .engineWrEn, .engineWrData,
		.hostReq, .hostAddr, .hostWrEn, .hostWrData,
		.rdData, .hostGrant
	);

endmodule

`default_nettype wire

/* routingNode_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module routingNodeChk (
	input logic clock,
	input logic rstN,
	input logic awvalid, awready, wvalid, wready, bvalid, bready,
	input logic [1:0] bresp,
	input logic arvalid, arready, rvalid, rready,
	input routingPkg::axiDataT rdata,
	input logic [1:0] rresp,
	input logic engineReq,
	input logic hostReq
);

	// requests stay up until taken
	awHeld: assert property (@(posedge clock) disable iff (!rstN)
		awvalid && !awready |=> awvalid) else $error("awvalid dropped before awready");
	wHeld: assert property (@(posedge clock) disable iff (!rstN)
		wvalid && !wready |=> wvalid) else $error("wvalid dropped before wready");
	arHeld: assert property (@(posedge clock) disable iff (!rstN)
		arvalid && !arready |=> arvalid) else $error("arvalid dropped before arready");

	// responses frozen under backpressure
	bHeld: assert property (@(posedge clock) disable iff (!rstN)
		bvalid && !bready |=> bvalid && $stable(bresp)) else $error("write response changed");
	rHeld: assert property (@(posedge clock) disable iff (!rstN)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else $error("read response changed");

	// a response only after its request
	bCause: assert property (@(posedge clock) disable iff (!rstN)
		$rose(bvalid) |-> $past(awvalid && awready && wvalid && wready))
		else $error("bvalid without write handshake");
	rCause: assert property (@(posedge clock) disable iff (!rstN)
		$rose(rvalid) |-> $past(arvalid && arready)) else $error("rvalid without read handshake");

	// one owner of the memory port
	portOwner: assert property (@(posedge clock) disable iff (!rstN)
		engineReq |-> !(hostReq && (awready || arready)))
		else $error("host memory access accepted while engine owns the port");

endmodule

bind routingNode routingNodeChk chk (.*);

`default_nettype wire

/* routingPkg.sv */
`default_nettype none

package routingPkg;

	// one table word, big-endian in memory
	typedef logic [15:0] wordT;
	// byte address into node memory
	typedef logic [10:0] memAddrT;
	typedef logic [15:0] axiAddrT;
	// only low half carries a table word
	typedef logic [31:0] axiDataT;

	// table bases used by the search
	localparam memAddrT neighborIdBase = 11'h048;
	localparam memAddrT clusterIdBase = 11'h0C8;
	localparam memAddrT qValueBase = 11'h1C8;
	localparam memAddrT betterNeighborBase = 11'h668;
	localparam memAddrT neighborCountAddr = 11'h68A;
	localparam memAddrT betterNeighborCountAddr = 11'h68C;

	// neighbor table length
	localparam int maxNeighbors = 64;

	// host register offsets
	localparam axiAddrT ctrlAddr = 16'h1000;
	localparam axiAddrT clusterAddr = 16'h1004;
	localparam axiAddrT statusAddr = 16'h1008;
	// memory window is everything below this
	localparam axiAddrT memWindowEnd = 16'h0800;

	// search engine states
	typedef enum logic [2:0] {
		idle, readCount, readCluster, readQ, readId, writeBest, writeCount
	} searchStateT;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# build with Verilator, run, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tbRoutingNode -f routingNode.f -o simRoutingNode \
	|| { echo "build failed"; exit 1; }
output=$(./obj_dir/simRoutingNode)
echo "$output"
echo "$output" | grep -qx "Test completed successfully" && exit 0 || exit 1

/* tbRoutingNode.sv */
`timescale 1ns/10ps
`default_nettype none

module tbRoutingNode;

	localparam int timeoutCycles = 500;

	logic clock, rstN;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	routingPkg::axiAddrT awaddr, araddr;
	routingPkg::axiDataT wdata, rdata;
	logic [1:0] bresp, rresp;

	// shadow copy of the neighbor tables
	routingPkg::wordT idTab [routingPkg::maxNeighbors];
	routingPkg::wordT clusterTab [routingPkg::maxNeighbors];
	routingPkg::wordT qTab [routingPkg::maxNeighbors];
	int tabCount;

	// results waiting for the compare process
	routingPkg::axiDataT gotQ [$];
	routingPkg::axiDataT expQ [$];
	string whatQ [$];

	routingNode #(.memDepth(2048)) uut (.*);

	// 20 ns period
	always #10 clock = ~clock;

	task automatic stopRun();
		$display("Test failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
			stopRun();
		end
	endtask

	task automatic timedOut(input string what);
		$display("timeout while waiting for %s", what);
		stopRun();
	endtask

	// byte address of entry i in a table
	function automatic routingPkg::axiAddrT memAxi(input routingPkg::memAddrT base, input int i);
		return 16'(base) + 16'(2 * i);
	endfunction

	task automatic axiWrite(input routingPkg::axiAddrT addr, input routingPkg::wordT value,
			input logic [1:0] expResp, input int hold);
		int cycles;
		logic [1:0] firstResp;
		@(negedge clock);
		awaddr = addr;
		wdata = {16'h0000, value};
		awvalid = 1'b1;
		wvalid = 1'b1;
		// ready is combinational so look mid low phase
		#5;
		cycles = 0;
		while (!(awready && wready)) begin
			cycles++;
			if (cycles > timeoutCycles) begin
				timedOut("write address and data handshake");
			end
			@(negedge clock);
			#5;
		end
		// handshake happens on the edge in between
		@(negedge clock);
		awvalid = 1'b0;
		wvalid = 1'b0;
		cycles = 0;
		while (!bvalid) begin
			cycles++;
			if (cycles > timeoutCycles) begin
				timedOut("write response");
			end
			@(negedge clock);
		end
		firstResp = bresp;
		// response has to sit still while bready is low
		for (int h = 0; h < hold; h++) begin
			@(negedge clock);
			check(32'(bvalid), 32'd1, "bvalid held under backpressure");
			check(32'(bresp), 32'(firstResp), "bresp held under backpressure");
		end
		bready = 1'b1;
		@(negedge clock);
		bready = 1'b0;
		check(32'(firstResp), 32'(expResp), "write response code");
	endtask

	task automatic axiRead(input routingPkg::axiAddrT addr, output routingPkg::axiDataT data,
			input logic [1:0] expResp, input int hold);
		int cycles;
		logic [1:0] firstResp;
		@(negedge clock);
		araddr = addr;
		arvalid = 1'b1;
		#5;
		cycles = 0;
		while (!arready) begin
			cycles++;
			if (cycles > timeoutCycles) begin
				timedOut("read address handshake");
			end
			@(negedge clock);
			#5;
		end
		@(negedge clock);
		arvalid = 1'b0;
		cycles = 0;
		while (!rvalid) begin
			cycles++;
			if (cycles > timeoutCycles) begin
				timedOut("read data");
			end
			@(negedge clock);
		end
		data = rdata;
		firstResp = rresp;
		for (int h = 0; h < hold; h++) begin
			@(negedge clock);
			check(32'(rvalid), 32'd1, "rvalid held under backpressure");
			check(rdata, data, "rdata held under backpressure");
			check(32'(rresp), 32'(firstResp), "rresp held under backpressure");
		end
		rready = 1'b1;
		@(negedge clock);
		rready = 1'b0;
		check(32'(firstResp), 32'(expResp), "read response code");
	endtask

	task automatic setEntry(input int i, input routingPkg::wordT id, input routingPkg::wordT cl,
			input routingPkg::wordT q);
		idTab[i] = id;
		clusterTab[i] = cl;
		qTab[i] = q;
	endtask

	task automatic loadTable(input int n);
		axiWrite(memAxi(routingPkg::neighborCountAddr, 0), 16'(n), 2'd0, 0);
		for (int i = 0; i < n; i++) begin
			axiWrite(memAxi(routingPkg::neighborIdBase, i), idTab[i], 2'd0, 0);
			axiWrite(memAxi(routingPkg::clusterIdBase, i), clusterTab[i], 2'd0, 0);
			axiWrite(memAxi(routingPkg::qValueBase, i), qTab[i], 2'd0, 0);
		end
		tabCount = n;
	endtask

	// bounded poll of status until done
	task automatic waitDone();
		routingPkg::axiDataT status;
		int polls;
		polls = 0;
		axiRead(routingPkg::statusAddr, status, 2'd0, 0);
		while (status[1] !== 1'b1) begin
			polls++;
			if (polls > timeoutCycles) begin
				timedOut("search done flag");
			end
			axiRead(routingPkg::statusAddr, status, 2'd0, 0);
		end
	endtask

	// set cluster and start, then expect busy and wait for done
	task automatic runSearch(input routingPkg::wordT myCl);
		routingPkg::axiDataT data;
		axiWrite(routingPkg::clusterAddr, myCl, 2'd0, 0);
		axiRead(routingPkg::clusterAddr, data, 2'd0, 0);
		check(data, {16'h0000, myCl}, "cluster register readback");
		axiWrite(routingPkg::ctrlAddr, 16'h0001, 2'd0, 0);
		axiRead(routingPkg::statusAddr, data, 2'd0, 0);
		check(32'(data[0]), 32'd1, "busy right after start");
		waitDone();
	endtask

	// read back the result words for the compare process
	task automatic queueResult(input routingPkg::wordT expId, input routingPkg::wordT expCnt,
			input string what);
		routingPkg::axiDataT data;
		axiRead(memAxi(routingPkg::betterNeighborBase, 0), data, 2'd0, 0);
		gotQ.push_back(data);
		expQ.push_back({16'h0000, expId});
		whatQ.push_back({what, " best neighbor"});
		axiRead(memAxi(routingPkg::betterNeighborCountAddr, 0), data, 2'd0, 0);
		gotQ.push_back(data);
		expQ.push_back({16'h0000, expCnt});
		whatQ.push_back({what, " best count"});
	endtask

	// highest Q among same-cluster neighbors where the first one wins a tie
	function automatic void bestNeighbor(input routingPkg::wordT myCl,
			output routingPkg::wordT bestId, output routingPkg::wordT bestCnt);
		routingPkg::wordT bestQ;
		int limit;
		bestId = '0;
		bestCnt = '0;
		bestQ = '0;
		limit = (tabCount > routingPkg::maxNeighbors) ? routingPkg::maxNeighbors : tabCount;
		for (int i = 0; i < limit; i++) begin
			if (clusterTab[i] == myCl && (bestCnt == 16'd0 || qTab[i] > bestQ)) begin
				bestId = idTab[i];
				bestQ = qTab[i];
				bestCnt = 16'd1;
			end
		end
	endfunction

	// compare process
	always @(posedge clock) begin
		if (gotQ.size() > 0) begin
			check(gotQ.pop_front(), expQ.pop_front(), whatQ.pop_front());
		end
	end

	initial begin
		routingPkg::axiDataT data;
		routingPkg::axiAddrT addr;
		routingPkg::wordT value, expId, expCnt, myCl;
		int n;
		void'($urandom(32'ha4e8));
		tabCount = 0;
		clock = 1'b0;
		rstN = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		repeat (10) @(negedge clock);
		rstN = 1'b1;

		// random words and backpressure with odd address aliasing the even one
		for (int k = 0; k < 8; k++) begin
			addr = 16'($urandom_range(0, 16'h07FF)) & 16'hFFFE;
			value = 16'($urandom);
			axiWrite(addr, value, 2'd0, $urandom_range(0, 3));
			axiRead(addr, data, 2'd0, $urandom_range(0, 3));
			check(data, {16'h0000, value}, "memory readback");
			axiRead(addr | 16'h0001, data, 2'd0, 0);
			check(data, {16'h0000, value}, "odd address alias");
		end

		// known scenario expects neighbor 3
		setEntry(0, 16'd1, 16'd9, 16'h0780);
		setEntry(1, 16'd3, 16'd1, 16'h0500);
		setEntry(2, 16'd4, 16'd1, 16'h0460);
		setEntry(3, 16'd6, 16'd3, 16'h0140);
		loadTable(4);
		runSearch(16'd1);
		queueResult(16'd3, 16'd1, "known scenario");

		// host read while the engine runs
		axiWrite(routingPkg::ctrlAddr, 16'h0001, 2'd0, 0);
		axiRead(memAxi(routingPkg::neighborIdBase, 1), data, 2'd0, 0);
		check(data, 32'd3, "memory read during search");
		axiRead(routingPkg::statusAddr, data, 2'd0, 0);
		check(data, 32'h2, "status after blocked read");

		// random tables where the first is empty and the second has no match
		for (int t = 0; t < 10; t++) begin
			n = (t == 0) ? 0 : int'($urandom_range(0, 20));
			for (int i = 0; i < n; i++) begin
				setEntry(i, 16'($urandom_range(1, 16'hFFFF)), 16'($urandom_range(0, 3)),
					16'($urandom_range(0, 7)) << 5);
			end
			myCl = (t == 1) ? 16'd7 : 16'($urandom_range(0, 3));
			loadTable(n);
			runSearch(myCl);
			bestNeighbor(myCl, expId, expCnt);
			queueResult(expId, expCnt, "random table");
		end

		// unmapped write is dropped and unmapped read gives zero
		axiWrite(16'h0100, 16'hBEEF, 2'd0, 0);
		axiWrite(16'h0900, 16'h1234, 2'd2, 0);
		axiRead(16'h0100, data, 2'd0, 0);
		check(data, 32'h0000BEEF, "memory after unmapped write");
		axiRead(16'h2000, data, 2'd2, 0);
		check(data, 32'h0, "unmapped read data");

		n = 0;
		while (gotQ.size() > 0) begin
			n++;
			if (n > timeoutCycles) begin
				timedOut("pending result compares");
			end
			@(negedge clock);
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
